// ==== cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 8;                 // Byte width of the datapath
    localparam int addrWidth = 8;                 // 256-byte address space
    localparam int flagWidth = 4;

    // Flag bit positions
    localparam int flagZ = 3;
    localparam int flagC = 2;
    localparam int flagN = 1;
    localparam int flagO = 0;

    // Opcodes, codes 14 and 15 behave as no-op
    localparam logic [3:0] opMov = 4'd0;
    localparam logic [3:0] opAnd = 4'd1;
    localparam logic [3:0] opOr  = 4'd2;
    localparam logic [3:0] opNot = 4'd3;
    localparam logic [3:0] opAdd = 4'd4;
    localparam logic [3:0] opSub = 4'd5;
    localparam logic [3:0] opLsl = 4'd6;
    localparam logic [3:0] opLsr = 4'd7;
    localparam logic [3:0] opInc = 4'd8;
    localparam logic [3:0] opDec = 4'd9;
    localparam logic [3:0] opBra = 4'd10;
    localparam logic [3:0] opBne = 4'd11;
    localparam logic [3:0] opLd  = 4'd12;
    localparam logic [3:0] opSt  = 4'd13;

    // Register codes, 6 and 7 read zero
    localparam logic [2:0] regR0 = 3'd0;
    localparam logic [2:0] regR1 = 3'd1;
    localparam logic [2:0] regR2 = 3'd2;
    localparam logic [2:0] regR3 = 3'd3;
    localparam logic [2:0] regAr = 3'd4;
    localparam logic [2:0] regPc = 3'd5;

    // ALU function codes
    localparam logic [3:0] aluPassA = 4'b0000;
    localparam logic [3:0] aluNot   = 4'b0010;
    localparam logic [3:0] aluAdd   = 4'b0100;
    localparam logic [3:0] aluSub   = 4'b0101;
    localparam logic [3:0] aluAnd   = 4'b0111;
    localparam logic [3:0] aluOr    = 4'b1000;
    localparam logic [3:0] aluLsl   = 4'b1011;
    localparam logic [3:0] aluLsr   = 4'b1100;
    localparam logic [3:0] aluInc   = 4'b1101;
    localparam logic [3:0] aluDec   = 4'b1110;

    // One instruction word, two decodings sharing the opcode field
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [2:0] dst;
            logic [2:0] src1;
            logic [2:0] src2;
            logic [2:0] unused;
        } regForm;
        struct packed {
            logic [3:0] opcode;
            logic [1:0] regSel;                   // R0 to R3
            logic       addrMode;                 // 0 immediate, 1 direct via AR
            logic       unused;
            logic [7:0] imm;                      // Immediate or branch target
        } memForm;
    } instrWord;

endpackage

`default_nettype wire

// ==== dataMem.sv ====
`timescale 1ns/100ps
`default_nettype none

module dataMem #(
    parameter int memWords = 256
) (
    input  wire logic                          clk,
    input  wire logic [cpuPkg::addrWidth-1:0]  fetchAddr,
    input  wire logic [cpuPkg::addrWidth-1:0]  dataAddr,
    input  wire logic [cpuPkg::addrWidth-1:0]  loadAddr,
    input  wire logic                          dataWrEn,
    input  wire logic                          loadEn,
    input  wire logic [cpuPkg::dataWidth-1:0]  dataWrData,
    input  wire logic [cpuPkg::dataWidth-1:0]  loadData,
    output logic      [cpuPkg::dataWidth-1:0]  fetchData,
    output logic      [cpuPkg::dataWidth-1:0]  dataRdData
);

    logic [cpuPkg::dataWidth-1:0] mem [memWords];

    // Both read ports are asynchronous
    assign fetchData  = mem[fetchAddr];
    assign dataRdData = mem[dataAddr];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;            // Host load wins over the core
        end else if (dataWrEn) begin
            mem[dataAddr] <= dataWrData;
        end
    end

endmodule

`default_nettype wire

// ==== fetchStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchStage #(
    parameter logic [cpuPkg::dataWidth-1:0] resetPc = '0
) (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic [cpuPkg::dataWidth-1:0]  fetchData,
    input  wire logic                          pcLoad,
    input  wire logic [cpuPkg::dataWidth-1:0]  pcTarget,
    output logic      [cpuPkg::addrWidth-1:0]  fetchAddr,
    output logic      [cpuPkg::dataWidth-1:0]  pc,
    output cpuPkg::instrWord                   instr,
    output logic                               execPhase
);

    logic [1:0] phase;                            // 0 low byte, 1 high byte, 2 execute

    assign fetchAddr = pc;
    assign execPhase = (phase == 2'd2);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= 2'd0;
            pc    <= resetPc;
        end else begin
            case (phase)
                2'd0, 2'd1: begin
                    phase <= phase + 2'd1;
                    pc    <= pc + 1'b1;
                end
                default: begin
                    phase <= 2'd0;
                    if (pcLoad) begin
                        pc <= pcTarget;           // Branch or write to PC
                    end
                end
            endcase
        end
    end

    // Instruction register, assembled little-endian
    always_ff @(posedge clk) begin
        if (phase == 2'd0) begin
            instr[7:0] <= fetchData;
        end
        if (phase == 2'd1) begin
            instr[15:8] <= fetchData;
        end
    end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic [2:0]                    rdAddrA,
    input  wire logic [2:0]                    rdAddrB,
    input  wire logic [2:0]                    wrAddr,
    input  wire logic                          wrEn,
    input  wire logic [cpuPkg::dataWidth-1:0]  wrData,
    output logic      [cpuPkg::dataWidth-1:0]  rdDataA,
    output logic      [cpuPkg::dataWidth-1:0]  rdDataB
);

    logic [cpuPkg::dataWidth-1:0] r0, r1, r2, r3, ar;

    function automatic logic [cpuPkg::dataWidth-1:0] readPort(input logic [2:0] sel);
        logic [cpuPkg::dataWidth-1:0] val;
        case (sel)
            cpuPkg::regR0: val = r0;
            cpuPkg::regR1: val = r1;
            cpuPkg::regR2: val = r2;
            cpuPkg::regR3: val = r3;
            cpuPkg::regAr: val = ar;
            default:       val = '0;              // PC comes from the execute stage
        endcase
        return val;
    endfunction

    always_comb begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            r0 <= '0;
            r1 <= '0;
            r2 <= '0;
            r3 <= '0;
            ar <= '0;
        end else if (wrEn) begin
            case (wrAddr)
                cpuPkg::regR0: r0 <= wrData;
                cpuPkg::regR1: r1 <= wrData;
                cpuPkg::regR2: r2 <= wrData;
                cpuPkg::regR3: r3 <= wrData;
                cpuPkg::regAr: ar <= wrData;
                default: ;                        // Codes 5 to 7 dropped
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== aluCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluCore (
    input  wire logic [3:0]                    aluOp,
    input  wire logic [cpuPkg::dataWidth-1:0]  opA,
    input  wire logic [cpuPkg::dataWidth-1:0]  opB,
    input  wire logic [cpuPkg::flagWidth-1:0]  flagsIn,
    output logic      [cpuPkg::dataWidth-1:0]  result,
    output logic      [cpuPkg::flagWidth-1:0]  flagsOut
);

    localparam int msb = cpuPkg::dataWidth - 1;

    logic [cpuPkg::dataWidth-1:0] addB;           // Second adder operand
    logic                         carryIn;
    logic [cpuPkg::dataWidth:0]   sum;
    logic                         carry;
    logic                         ovf;

    // One adder serves ADD, SUB, INC and DEC
    always_comb begin
        addB    = opB;
        carryIn = 1'b0;
        case (aluOp)
            cpuPkg::aluSub: begin
                addB    = ~opB;
                carryIn = 1'b1;
            end
            cpuPkg::aluInc: begin
                addB    = '0;
                carryIn = 1'b1;
            end
            cpuPkg::aluDec: addB = '1;            // A + 0xFF, carry set unless A is 0
            default: ;
        endcase
        sum = {1'b0, opA} + {1'b0, addB} + carryIn;
    end

    always_comb begin
        result = opA;
        carry  = flagsIn[cpuPkg::flagC];
        ovf    = flagsIn[cpuPkg::flagO];
        case (aluOp)
            cpuPkg::aluNot: result = ~opA;
            cpuPkg::aluAnd: result = opA & opB;
            cpuPkg::aluOr:  result = opA | opB;
            cpuPkg::aluAdd, cpuPkg::aluSub: begin
                result = sum[msb:0];
                carry  = sum[msb+1];
                ovf    = (opA[msb] == addB[msb]) && (sum[msb] != opA[msb]);
            end
            cpuPkg::aluInc, cpuPkg::aluDec: begin
                result = sum[msb:0];
                carry  = sum[msb+1];
            end
            cpuPkg::aluLsl: begin
                result = {opA[msb-1:0], 1'b0};
                carry  = opA[msb];
            end
            cpuPkg::aluLsr: begin
                result = {1'b0, opA[msb:1]};
                carry  = opA[0];
            end
            default: ;                            // PassA
        endcase
    end

    always_comb begin
        flagsOut                = flagsIn;
        flagsOut[cpuPkg::flagZ] = (result == '0);
        flagsOut[cpuPkg::flagN] = result[msb];
        flagsOut[cpuPkg::flagC] = carry;
        flagsOut[cpuPkg::flagO] = ovf;
    end

endmodule

`default_nettype wire

// ==== execStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execStage (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic                          execPhase,
    input  wire cpuPkg::instrWord              instr,
    input  wire logic [cpuPkg::dataWidth-1:0]  pc,
    input  wire logic [cpuPkg::dataWidth-1:0]  rdDataA,
    input  wire logic [cpuPkg::dataWidth-1:0]  rdDataB,
    input  wire logic [cpuPkg::dataWidth-1:0]  dataRdData,
    input  wire logic [cpuPkg::dataWidth-1:0]  result,
    input  wire logic [cpuPkg::flagWidth-1:0]  flagsOut,
    output logic      [2:0]                    rdAddrA,
    output logic      [2:0]                    rdAddrB,
    output logic      [2:0]                    wrAddr,
    output logic                               wrEn,
    output logic                               dataWrEn,
    output logic                               pcLoad,
    output logic      [cpuPkg::dataWidth-1:0]  wrData,
    output logic      [cpuPkg::dataWidth-1:0]  dataAddr,
    output logic      [cpuPkg::dataWidth-1:0]  dataWrData,
    output logic      [cpuPkg::dataWidth-1:0]  pcTarget,
    output logic      [cpuPkg::dataWidth-1:0]  opA,
    output logic      [cpuPkg::dataWidth-1:0]  opB,
    output logic      [3:0]                    aluOp,
    output logic      [cpuPkg::flagWidth-1:0]  flagsIn,
    output logic                               retirePulse,
    output logic      [cpuPkg::dataWidth-1:0]  retireData,
    output logic      [cpuPkg::flagWidth-1:0]  retireFlags
);

    logic [cpuPkg::flagWidth-1:0] flags, nextFlags;
    logic [cpuPkg::dataWidth-1:0] retireValue;
    logic                         wbEn, stEn, brTake, flagUpdate;

    // Source code 5 reads the live PC
    assign opA = (instr.regForm.src1 == cpuPkg::regPc) ? pc : rdDataA;
    assign opB = (instr.regForm.src2 == cpuPkg::regPc) ? pc : rdDataB;

    assign dataAddr   = rdDataA;                  // AR on port A for LD and ST
    assign dataWrData = rdDataB;
    assign flagsIn    = flags;

    always_comb begin
        rdAddrA     = instr.regForm.src1;
        rdAddrB     = instr.regForm.src2;
        wrAddr      = instr.regForm.dst;
        wrData      = result;
        pcTarget    = instr.memForm.imm;
        retireValue = result;
        wbEn        = 1'b0;
        stEn        = 1'b0;
        brTake      = 1'b0;
        flagUpdate  = 1'b0;
        case (instr.regForm.opcode)
            cpuPkg::opMov, cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opNot, cpuPkg::opAdd,
            cpuPkg::opSub, cpuPkg::opLsl, cpuPkg::opLsr, cpuPkg::opInc, cpuPkg::opDec: begin
                flagUpdate = 1'b1;
                if (instr.regForm.dst == cpuPkg::regPc) begin
                    brTake   = 1'b1;              // Write to PC acts as a jump
                    pcTarget = result;
                end else begin
                    wbEn = 1'b1;
                end
            end
            cpuPkg::opLd: begin
                rdAddrA     = cpuPkg::regAr;
                wrAddr      = {1'b0, instr.memForm.regSel};
                wrData      = instr.memForm.addrMode ? dataRdData : instr.memForm.imm;
                wbEn        = 1'b1;
                retireValue = wrData;
            end
            cpuPkg::opSt: begin
                rdAddrA     = cpuPkg::regAr;
                rdAddrB     = {1'b0, instr.memForm.regSel};
                stEn        = instr.memForm.addrMode; // Direct only
                retireValue = rdDataB;
            end
            cpuPkg::opBra: begin
                brTake      = 1'b1;
                retireValue = instr.memForm.imm;
            end
            cpuPkg::opBne: begin
                brTake      = !flags[cpuPkg::flagZ];
                retireValue = brTake ? instr.memForm.imm : pc;
            end
            default: retireValue = pc;            // No-op
        endcase
    end

    always_comb begin
        case (instr.regForm.opcode)
            cpuPkg::opAnd: aluOp = cpuPkg::aluAnd;
            cpuPkg::opOr:  aluOp = cpuPkg::aluOr;
            cpuPkg::opNot: aluOp = cpuPkg::aluNot;
            cpuPkg::opAdd: aluOp = cpuPkg::aluAdd;
            cpuPkg::opSub: aluOp = cpuPkg::aluSub;
            cpuPkg::opLsl: aluOp = cpuPkg::aluLsl;
            cpuPkg::opLsr: aluOp = cpuPkg::aluLsr;
            cpuPkg::opInc: aluOp = cpuPkg::aluInc;
            cpuPkg::opDec: aluOp = cpuPkg::aluDec;
            default:       aluOp = cpuPkg::aluPassA;
        endcase
    end

    // Side effects only in the execute cycle
    assign wrEn      = execPhase & wbEn;
    assign dataWrEn  = execPhase & stEn;
    assign pcLoad    = execPhase & brTake;
    assign nextFlags = flagUpdate ? flagsOut : flags;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flags       <= '0;
            retirePulse <= 1'b0;
            retireData  <= '0;
            retireFlags <= '0;
        end else begin
            retirePulse <= execPhase;
            if (execPhase) begin
                flags       <= nextFlags;
                retireData  <= retireValue;
                retireFlags <= nextFlags;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cpuTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuTop (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic                          loadEn,
    input  wire logic [cpuPkg::addrWidth-1:0]  loadAddr,
    input  wire logic [cpuPkg::dataWidth-1:0]  loadData,
    output logic                               retirePulse,
    output logic      [cpuPkg::dataWidth-1:0]  retireData,
    output logic      [cpuPkg::flagWidth-1:0]  retireFlags
);

    localparam int                           memWords = 256;
    localparam logic [cpuPkg::dataWidth-1:0] resetPc  = 8'h00;

    logic [cpuPkg::addrWidth-1:0] fetchAddr;
    logic [cpuPkg::dataWidth-1:0] fetchData, pc, pcTarget;
    logic [cpuPkg::dataWidth-1:0] dataAddr, dataWrData, dataRdData;
    logic [cpuPkg::dataWidth-1:0] rdDataA, rdDataB, wrData;
    logic [cpuPkg::dataWidth-1:0] opA, opB, result;
    logic [cpuPkg::flagWidth-1:0] flagsIn, flagsOut;
    logic [2:0]                   rdAddrA, rdAddrB, wrAddr;
    logic [3:0]                   aluOp;
    logic                         pcLoad, execPhase, wrEn, dataWrEn;
    cpuPkg::instrWord             instr;

    dataMem #(.memWords(memWords)) uMem (
        .clk(clk), .fetchAddr(fetchAddr), .dataAddr(dataAddr), .loadAddr(loadAddr),
        .dataWrEn(dataWrEn), .loadEn(loadEn), .dataWrData(dataWrData),
        .loadData(loadData), .fetchData(fetchData), .dataRdData(dataRdData)
    );

    fetchStage #(.resetPc(resetPc)) uFetch (
        .clk(clk), .rstN(rstN), .fetchData(fetchData), .pcLoad(pcLoad),
        .pcTarget(pcTarget), .fetchAddr(fetchAddr), .pc(pc), .instr(instr),
        .execPhase(execPhase)
    );

    regFile uRegs (
        .clk(clk), .rstN(rstN), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .wrAddr(wrAddr),
        .wrEn(wrEn), .wrData(wrData), .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    aluCore uAlu (
        .aluOp(aluOp), .opA(opA), .opB(opB), .flagsIn(flagsIn),
        .result(result), .flagsOut(flagsOut)
    );

    execStage uExec (
        .clk(clk), .rstN(rstN), .execPhase(execPhase), .instr(instr), .pc(pc),
        .rdDataA(rdDataA), .rdDataB(rdDataB), .dataRdData(dataRdData),
        .result(result), .flagsOut(flagsOut), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .wrAddr(wrAddr), .wrEn(wrEn), .dataWrEn(dataWrEn), .pcLoad(pcLoad),
        .wrData(wrData), .dataAddr(dataAddr), .dataWrData(dataWrData),
        .pcTarget(pcTarget), .opA(opA), .opB(opB), .aluOp(aluOp), .flagsIn(flagsIn),
        .retirePulse(retirePulse), .retireData(retireData), .retireFlags(retireFlags)
    );

endmodule

`default_nettype wire

// ==== cpuTop_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuTopSva (
    input wire logic                         clk,
    input wire logic                         rstN,
    input wire logic                         retirePulse,
    input wire logic [cpuPkg::flagWidth-1:0] retireFlags
);

    // Every pulse is answered by the next one three cycles on
    pulseFollows: assert property (@(posedge clk) disable iff (!rstN)
        $past(retirePulse, 3) |-> retirePulse)
        else $error("retirePulse missing three cycles after the previous one");

    pulseGap: assert property (@(posedge clk) disable iff (!rstN)
        retirePulse |-> !$past(retirePulse, 1) && !$past(retirePulse, 2))
        else $error("retirePulse came less than three cycles after the previous one");

    noPulseInReset: assert property (@(posedge clk) !rstN |-> !retirePulse)
        else $error("retirePulse high during reset");

    flagsHold: assert property (@(posedge clk) disable iff (!rstN)
        !retirePulse |-> $stable(retireFlags))
        else $error("retireFlags changed between retire pulses");

endmodule

bind cpuTop cpuTopSva uSva (
    .clk(clk),
    .rstN(rstN),
    .retirePulse(retirePulse),
    .retireFlags(retireFlags)
);

`default_nettype wire

// ==== tbClock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
    parameter int halfPeriod  = 5,
    parameter int resetCycles = 4
) (
    output logic            clk,
    output logic            rstN,
    input  wire logic       holdReset                 // Keeps reset low while the program loads
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        rstN = 1'b1;
        #1 rstN = 1'b0;                               // Falling edge starts the async reset
        repeat (resetCycles) @(posedge clk);
        while (holdReset) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== cpuTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuTb;

    localparam int numRows    = 31;
    localparam int loadCycles = 2 * numRows + 8;      // Two bytes per row plus reset margin
    localparam int timeoutNs  = (numRows * 3 + loadCycles + 20) * 10;

    localparam logic [2:0] r0  = cpuPkg::regR0;
    localparam logic [2:0] r1  = cpuPkg::regR1;
    localparam logic [2:0] r2  = cpuPkg::regR2;
    localparam logic [2:0] r3  = cpuPkg::regR3;
    localparam logic [2:0] rAr = cpuPkg::regAr;
    localparam logic [2:0] rPc = cpuPkg::regPc;

    logic                         clk;
    logic                         rstN;
    logic                         loadBusy;
    logic                         loadEn;
    logic [cpuPkg::addrWidth-1:0] loadAddr;
    logic [cpuPkg::dataWidth-1:0] loadData;
    logic                         retirePulse;
    logic [cpuPkg::dataWidth-1:0] retireData;
    logic [cpuPkg::flagWidth-1:0] retireFlags;

    // Program rows in execution order, flags written as Z C N O
    logic [cpuPkg::addrWidth-1:0] rowAddr  [numRows];
    cpuPkg::instrWord             rowInstr [numRows];
    logic [cpuPkg::dataWidth-1:0] rowData  [numRows];
    logic [cpuPkg::flagWidth-1:0] rowFlags [numRows];
    int                           rowCount;

    tbClock #(.halfPeriod(5), .resetCycles(4)) uClock (
        .clk(clk),
        .rstN(rstN),
        .holdReset(loadBusy)
    );

    cpuTop UUT (
        .clk(clk),
        .rstN(rstN),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .retirePulse(retirePulse),
        .retireData(retireData),
        .retireFlags(retireFlags)
    );

    function automatic cpuPkg::instrWord regOp(input logic [3:0] op,
                                               input logic [2:0] dst, src1, src2);
        cpuPkg::instrWord w;
        w.regForm.opcode = op;
        w.regForm.dst    = dst;
        w.regForm.src1   = src1;
        w.regForm.src2   = src2;
        w.regForm.unused = 3'b000;
        return w;
    endfunction

    function automatic cpuPkg::instrWord memOp(input logic [3:0] op, input logic [1:0] sel,
                                               input logic mode, input logic [7:0] imm);
        cpuPkg::instrWord w;
        w.memForm.opcode   = op;
        w.memForm.regSel   = sel;
        w.memForm.addrMode = mode;
        w.memForm.unused   = 1'b0;
        w.memForm.imm      = imm;
        return w;
    endfunction

    task automatic addRow(input logic [7:0] addr, input cpuPkg::instrWord w,
                          input logic [7:0] data, input logic [3:0] flags);
        rowAddr[rowCount]  = addr;
        rowInstr[rowCount] = w;
        rowData[rowCount]  = data;
        rowFlags[rowCount] = flags;
        rowCount++;
    endtask

    task automatic buildProgram();
        addRow(8'h00, memOp(cpuPkg::opLd, 2'd0, 1'b0, 8'h25), 8'h25, 4'b0000);
        addRow(8'h02, memOp(cpuPkg::opLd, 2'd1, 1'b0, 8'h5A), 8'h5A, 4'b0000);
        addRow(8'h04, regOp(cpuPkg::opAdd, r2, r0, r1), 8'h7F, 4'b0000);
        addRow(8'h06, memOp(cpuPkg::opLd, 2'd3, 1'b0, 8'h01), 8'h01, 4'b0000);
        addRow(8'h08, regOp(cpuPkg::opAdd, r2, r2, r3), 8'h80, 4'b0011);  // Signed overflow
        addRow(8'h0A, regOp(cpuPkg::opAdd, r0, r2, r2), 8'h00, 4'b1101);
        addRow(8'h0C, regOp(cpuPkg::opSub, r0, r1, r3), 8'h59, 4'b0100);  // No borrow
        addRow(8'h0E, regOp(cpuPkg::opAnd, r3, r1, r2), 8'h00, 4'b1100);
        addRow(8'h10, regOp(cpuPkg::opOr, r3, r1, r2), 8'hDA, 4'b0110);
        addRow(8'h12, regOp(cpuPkg::opNot, r3, r3, r0), 8'h25, 4'b0100);
        addRow(8'h14, regOp(cpuPkg::opLsl, r0, r2, r0), 8'h00, 4'b1100);  // 0x80 shifted out
        addRow(8'h16, regOp(cpuPkg::opLsr, r0, r1, r0), 8'h2D, 4'b0000);
        addRow(8'h18, regOp(cpuPkg::opInc, r0, r0, r0), 8'h2E, 4'b0000);
        addRow(8'h1A, memOp(cpuPkg::opLd, 2'd1, 1'b0, 8'h01), 8'h01, 4'b0000);
        addRow(8'h1C, regOp(cpuPkg::opDec, r1, r1, r0), 8'h00, 4'b1100);  // Down to zero
        addRow(8'h1E, memOp(cpuPkg::opBne, 2'd0, 1'b0, 8'h40), 8'h20, 4'b1100);
        addRow(8'h20, memOp(cpuPkg::opLd, 2'd2, 1'b0, 8'hF0), 8'hF0, 4'b1100);
        addRow(8'h22, regOp(cpuPkg::opMov, rAr, r2, r0), 8'hF0, 4'b0110);
        addRow(8'h24, memOp(cpuPkg::opLd, 2'd3, 1'b0, 8'hA5), 8'hA5, 4'b0110);
        addRow(8'h26, memOp(cpuPkg::opSt, 2'd3, 1'b1, 8'h00), 8'hA5, 4'b0110);
        addRow(8'h28, memOp(cpuPkg::opLd, 2'd0, 1'b1, 8'h00), 8'hA5, 4'b0110);
        addRow(8'h2A, regOp(cpuPkg::opMov, r1, r0, r0), 8'hA5, 4'b0110);
        addRow(8'h2C, memOp(cpuPkg::opBne, 2'd0, 1'b0, 8'h34), 8'h34, 4'b0110);
        addRow(8'h34, memOp(cpuPkg::opLd, 2'd0, 1'b0, 8'h11), 8'h11, 4'b0110);
        addRow(8'h36, memOp(cpuPkg::opBra, 2'd0, 1'b0, 8'h50), 8'h50, 4'b0110);
        addRow(8'h50, memOp(cpuPkg::opLd, 2'd1, 1'b0, 8'h22), 8'h22, 4'b0110);
        addRow(8'h52, regOp(cpuPkg::opMov, r2, rPc, r0), 8'h54, 4'b0100); // PC past this word
        addRow(8'h54, memOp(cpuPkg::opLd, 2'd3, 1'b0, 8'h60), 8'h60, 4'b0100);
        addRow(8'h56, regOp(cpuPkg::opMov, rPc, r3, r0), 8'h60, 4'b0100);
        addRow(8'h60, memOp(cpuPkg::opLd, 2'd0, 1'b0, 8'h33), 8'h33, 4'b0100);
        addRow(8'h62, memOp(cpuPkg::opBra, 2'd0, 1'b0, 8'h62), 8'h62, 4'b0100);  // Parks the core
    endtask

    task automatic checkData(input string name, input logic [cpuPkg::dataWidth-1:0] got,
                             input logic [cpuPkg::dataWidth-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Retire data mismatch");
        end
    endtask

    task automatic checkFlags(input string name, input logic [cpuPkg::flagWidth-1:0] got,
                              input logic [cpuPkg::flagWidth-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Retire flags mismatch");
        end
    endtask

    // Outputs settle after the rising edge, so look at the falling edge
    task automatic waitRetire();
        do begin
            @(negedge clk);
        end while (retirePulse !== 1'b1);
    endtask

    initial begin
        loadBusy  = 1'b1;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        rowCount  = 0;
        buildProgram();
        wait (rstN === 1'b0);
        for (int i = 0; i < numRows; i++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= rowAddr[i];
            loadData <= rowInstr[i][7:0];                 // Low byte first
            @(posedge clk);
            loadAddr <= rowAddr[i] + 8'd1;
            loadData <= rowInstr[i][15:8];
        end
        @(posedge clk);
        loadEn   <= 1'b0;
        loadBusy <= 1'b0;
        wait (rstN === 1'b1);
        for (int i = 0; i < numRows; i++) begin
            waitRetire();
            checkData($sformatf("retireData[row %0d]", i), retireData, rowData[i]);
            checkFlags($sformatf("retireFlags[row %0d]", i), retireFlags, rowFlags[i]);
        end
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("Watchdog expired after %0d ns before all rows retired", timeoutNs);
        $display("RESULT: FAIL");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// ==== all.f ====
cpuPkg.sv
dataMem.sv
fetchStage.sv
regFile.sv
aluCore.sv
execStage.sv
cpuTop.sv
cpuTop_sva.sv
tbClock.sv
cpuTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cpuTb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
